// ==== console_pkg.sv ====
package console_pkg;

    // Bus geometry
    localparam int word_w     = 32;
    localparam int ring_depth = 16;
    localparam int idx_w      = 4;   // Head and tail index width
    localparam int addr_w     = 5;   // Word address width

    // Word address map
    localparam logic [addr_w-1:0] addr_head   = 5'd0;  // Read/write
    localparam logic [addr_w-1:0] addr_status = 5'd1;  // Read-only
    localparam logic [addr_w-1:0] addr_slot0  = 5'd2;  // Slot k at 2 + k
    localparam logic [addr_w-1:0] addr_slot_last = addr_slot0 + addr_w'(ring_depth - 1);

    // Status word layout, tail sits in the low idx_w bits
    localparam int status_busy_bit = 8;

    // Character byte taken from the top of each slot word
    localparam int char_msb = 31;

    // Bit period in clk cycles
    localparam int clks_per_bit = 8;
    localparam int baud_cnt_w   = $clog2(clks_per_bit);

    typedef enum logic [1:0] {
        idle,
        start_bit,
        data_bits,
        stop_bit
    } tx_state_e;

endpackage

// ==== tx_ctrl_if.sv ====
`timescale 1ns/10ps

interface tx_ctrl_if;

    logic       run;       // Timer enable for the whole frame
    logic       bit_tick;  // End of a bit period
    logic       load;      // Capture frame, pop ring
    logic       shift;     // Advance to next bit
    logic [7:0] tx_byte;   // Byte at the current tail

    modport ctrl    (output run, output load, output shift, input bit_tick);
    modport timer   (input run, output bit_tick);
    modport shifter (input load, input shift, input tx_byte);
    modport regs    (input load, output tx_byte);

endinterface

// ==== console_regs.sv ====
`timescale 1ns/10ps

module console_regs
    import console_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              bus_we,
    input  logic [addr_w-1:0] bus_addr,
    input  logic [word_w-1:0] bus_wdata,
    output logic [word_w-1:0] bus_rdata,
    input  logic              busy,
    output logic              pending,
    tx_ctrl_if.regs           ctl
);

    logic [idx_w-1:0]  head;   // Written by software
    logic [idx_w-1:0]  tail;   // Advanced by hardware
    logic [word_w-1:0] slots [ring_depth];

    logic              is_slot;
    logic [idx_w-1:0]  slot_idx;
    logic [word_w-1:0] rd_next;

    assign is_slot  = (bus_addr >= addr_slot0) && (bus_addr <= addr_slot_last);
    assign slot_idx = idx_w'(bus_addr - addr_slot0);

    // Anything left between tail and head still needs sending
    assign pending = (head != tail);

    assign ctl.tx_byte = slots[tail][char_msb -: 8];

    // Bus writes, status and unused addresses fall through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            for (int i = 0; i < ring_depth; i++) begin
                slots[i] <= '0;
            end
        end else if (bus_we) begin
            if (bus_addr == addr_head) begin
                head <= bus_wdata[idx_w-1:0];  // Low bits only
            end else if (is_slot) begin
                slots[slot_idx] <= bus_wdata;
            end
        end
    end

    // Tail wraps by index width, i.e. modulo ring_depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (ctl.load) begin
            tail <= tail + 1'b1;
        end
    end

    // Read decode
    always_comb begin
        rd_next = '0;
        if (bus_addr == addr_head) begin
            rd_next = word_w'(head);
        end else if (bus_addr == addr_status) begin
            rd_next[idx_w-1:0]       = tail;
            rd_next[status_busy_bit] = busy;
        end else if (is_slot) begin
            rd_next = slots[slot_idx];
        end
    end

    // One cycle read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_rdata <= '0;
        end else begin
            bus_rdata <= rd_next;
        end
    end

endmodule

// ==== uart_tx_fsm.sv ====
`timescale 1ns/10ps

module uart_tx_fsm
    import console_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pending,
    output logic    busy,
    tx_ctrl_if.ctrl ctl
);

    tx_state_e  state;
    logic [2:0] bit_cnt;   // Data bit in flight
    logic       load_q;

    assign ctl.load = load_q;
    assign ctl.run  = (state != idle);
    assign busy     = (state != idle);

    // Every tick moves the line on, except the one closing the stop bit
    assign ctl.shift = ctl.bit_tick && (state == start_bit || state == data_bits);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            bit_cnt <= '0;
            load_q  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (load_q) begin
                        // Shifter captures and tail pops on this edge
                        load_q <= 1'b0;
                        state  <= start_bit;
                    end else begin
                        load_q <= pending;
                    end
                end
                start_bit: begin
                    if (ctl.bit_tick) begin
                        state   <= data_bits;
                        bit_cnt <= '0;
                    end
                end
                data_bits: begin
                    if (ctl.bit_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= stop_bit;
                        end
                    end
                end
                stop_bit: begin
                    if (ctl.bit_tick) begin
                        state  <= idle;
                        load_q <= pending;  // Back-to-back frame
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== baud_timer.sv ====
`timescale 1ns/10ps

module baud_timer
    import console_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    tx_ctrl_if.timer ctl
);

    localparam logic [baud_cnt_w-1:0] reload = baud_cnt_w'(clks_per_bit - 1);

    logic [baud_cnt_w-1:0] cnt;

    // Held at reload while idle so the first bit is a full period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= reload;
        end else if (!ctl.run || cnt == '0) begin
            cnt <= reload;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign ctl.bit_tick = ctl.run && (cnt == '0);

endmodule

// ==== tx_shifter.sv ====
`timescale 1ns/10ps

module tx_shifter (
    input  logic       clk,
    input  logic       rst_n,
    tx_ctrl_if.shifter ctl,
    output logic       txd
);

    // Stop, data, start from msb down, so start goes out first
    logic [9:0] frame;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame <= '1;  // Line idles high
        end else if (ctl.load) begin
            frame <= {1'b1, ctl.tx_byte, 1'b0};
        end else if (ctl.shift) begin
            frame <= {1'b1, frame[9:1]};  // LSB first
        end
    end

    assign txd = frame[0];

endmodule

// ==== uart_console.sv ====
`timescale 1ns/10ps

module uart_console
    import console_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              bus_we,
    input  logic [addr_w-1:0] bus_addr,
    input  logic [word_w-1:0] bus_wdata,
    output logic [word_w-1:0] bus_rdata,
    output logic              txd
);

    logic pending;  // Ring not empty
    logic busy;     // Frame in progress

    tx_ctrl_if u_ctl ();

    console_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .busy      (busy),
        .pending   (pending),
        .ctl       (u_ctl.regs)
    );

    uart_tx_fsm u_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .pending (pending),
        .busy    (busy),
        .ctl     (u_ctl.ctrl)
    );

    baud_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .ctl   (u_ctl.timer)
    );

    tx_shifter u_shifter (
        .clk   (clk),
        .rst_n (rst_n),
        .ctl   (u_ctl.shifter),
        .txd   (txd)
    );

endmodule

// ==== console_checker.sv ====
`timescale 1ns/10ps

module console_checker
    import console_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              bus_we,
    input  logic [addr_w-1:0] bus_addr,
    input  logic [word_w-1:0] bus_wdata,
    input  logic [word_w-1:0] bus_rdata,
    input  logic              txd,
    input  logic              chk_en,     // Expected read port
    input  logic [word_w-1:0] chk_data,
    input  logic [word_w-1:0] chk_mask,
    input  logic              end_of_test,
    output int                read_errs,
    output int                byte_errs,
    output int                proto_errs,
    output int                pending_left
);

    logic [idx_w-1:0]  head_m;
    logic [idx_w-1:0]  tail_m = '0;  // Next slot due on txd
    logic [idx_w-1:0]  diff;
    logic [word_w-1:0] slots_m [ring_depth];

    logic              chk_q;
    logic [word_w-1:0] chk_data_q;
    logic [word_w-1:0] chk_mask_q;
    logic [addr_w-1:0] chk_addr_q;
    logic [7:0]        rx_byte;
    logic              rx_stop;

    int n_read  = 0;
    int n_byte  = 0;
    int n_proto = 0;

    assign read_errs    = n_read;
    assign byte_errs    = n_byte;
    assign proto_errs   = n_proto;
    assign diff         = head_m - tail_m;  // Wraps like the ring
    assign pending_left = int'(diff);

    // Ring model built from bus writes
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_m <= '0;
            for (int i = 0; i < ring_depth; i++) begin
                slots_m[i] <= '0;
            end
        end else if (bus_we) begin
            if (bus_addr == addr_head) begin
                head_m <= bus_wdata[idx_w-1:0];
            end else if (bus_addr >= addr_slot0 && bus_addr < addr_slot0 + ring_depth) begin
                slots_m[idx_w'(bus_addr - addr_slot0)] <= bus_wdata;
            end
        end
    end

    // Read data shows up one edge after the address
    always @(posedge clk) begin
        chk_q      <= chk_en;
        chk_data_q <= chk_data;
        chk_mask_q <= chk_mask;
        chk_addr_q <= bus_addr;
    end

    always @(negedge clk) begin
        if (rst_n && chk_q && ((bus_rdata ^ chk_data_q) & chk_mask_q) !== '0) begin
            n_read++;
            $display("[FAIL] %0t bus_rdata at word address %0d (mask %h): expected %h, got %h",
                     $time, chk_addr_q, chk_mask_q, chk_data_q, bus_rdata);
        end
    end

    task automatic take_byte(input logic [7:0] b, input logic stop);
        logic [7:0] exp_b;
        if (stop !== 1'b1) begin
            n_proto++;
            $display("Framing error at %0t, stop bit on txd was low", $time);
        end
        if (head_m == tail_m) begin
            n_proto++;
            $display("Byte %h arrived on txd at %0t with nothing pending", b, $time);
        end else begin
            exp_b = slots_m[tail_m][char_msb -: 8];
            if (b !== exp_b) begin
                n_byte++;
                $display("[FAIL] %0t txd byte from slot %0d: expected %h, got %h",
                         $time, tail_m, exp_b, b);
            end
            tail_m = tail_m + 1'b1;
        end
    endtask

    // Serial decoder sampling txd on the falling clock edge near mid-bit
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && txd === 1'b0) begin
                repeat (clks_per_bit / 2 - 1) @(negedge clk);
                if (txd !== 1'b0) begin
                    n_proto++;
                    $display("Start bit on txd at %0t ended before mid-bit", $time);
                end else begin
                    for (int b = 0; b < 8; b++) begin
                        repeat (clks_per_bit) @(negedge clk);
                        rx_byte[b] = txd;  // LSB first
                    end
                    repeat (clks_per_bit) @(negedge clk);
                    rx_stop = txd;
                    take_byte(rx_byte, rx_stop);
                end
            end
        end
    end

    always @(posedge end_of_test) begin
        if (diff != '0) begin
            $display("%0d bytes were still pending in the ring at the end of the run", diff);
        end
    end

endmodule

// ==== tb_uart_console.sv ====
`timescale 1ns/10ps

module tb_uart_console
    import console_pkg::*;
();

    typedef enum logic [1:0] {op_write, op_read, op_wait} op_e;

    typedef struct packed {
        op_e               op;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] data;     // Write data or head to wait for
        logic [word_w-1:0] exp_val;
        logic [word_w-1:0] mask;     // Bits of exp_val that are known
    } entry_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              bus_we;
    logic [addr_w-1:0] bus_addr;
    logic [word_w-1:0] bus_wdata;
    logic [word_w-1:0] bus_rdata;
    logic              txd;
    logic              chk_en;
    logic [word_w-1:0] chk_data;
    logic [word_w-1:0] chk_mask;
    logic              end_of_test;
    int                read_errs;
    int                byte_errs;
    int                proto_errs;
    int                pending_left;

    entry_t            tbl [$];
    logic [word_w-1:0] rng;
    logic [word_w-1:0] sw_slots [ring_depth];  // What software wrote
    logic [idx_w-1:0]  sw_head;
    int                n_bytes;
    int                cycle_cnt = 0;
    int                cycle_limit = 0;

    always #4 clk = ~clk;

    uart_console u_uart_console (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .txd       (txd)
    );

    console_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_we       (bus_we),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_rdata    (bus_rdata),
        .txd          (txd),
        .chk_en       (chk_en),
        .chk_data     (chk_data),
        .chk_mask     (chk_mask),
        .end_of_test  (end_of_test),
        .read_errs    (read_errs),
        .byte_errs    (byte_errs),
        .proto_errs   (proto_errs),
        .pending_left (pending_left)
    );

    function automatic logic [word_w-1:0] xorshift32(input logic [word_w-1:0] s);
        logic [word_w-1:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic add_write(input logic [addr_w-1:0] a, input logic [word_w-1:0] d);
        tbl.push_back('{op_write, a, d, '0, '0});
    endtask

    task automatic add_read(input logic [addr_w-1:0] a, input logic [word_w-1:0] exp_val,
                            input logic [word_w-1:0] mask);
        tbl.push_back('{op_read, a, '0, exp_val, mask});
    endtask

    task automatic add_wait();
        tbl.push_back('{op_wait, addr_status, word_w'(sw_head), '0, '0});
    endtask

    // New random character word into slot k
    task automatic add_char(input int k);
        rng = xorshift32(rng);
        sw_slots[k] = rng;
        add_write(addr_slot0 + addr_w'(k), rng);
    endtask

    task automatic set_head(input logic [idx_w-1:0] h);
        logic [idx_w-1:0] added;
        added = h - sw_head;  // Modulo ring_depth
        n_bytes += int'(added);
        sw_head = h;
        add_write(addr_head, word_w'(h));
    endtask

    task automatic read_slot(input int k);
        add_read(addr_slot0 + addr_w'(k), sw_slots[k], '1);
    endtask

    task automatic build_table();
        // Reset values
        add_read(addr_head, '0, '1);
        add_read(addr_status, '0, '1);
        read_slot(0);
        read_slot(7);
        read_slot(ring_depth - 1);
        // Single character
        add_char(0);
        set_head(1);
        add_wait();
        add_read(addr_status, word_w'(sw_head), '1);
        // Burst of six with busy sampled mid-burst
        for (int k = 1; k <= 6; k++) begin
            add_char(k);
        end
        set_head(7);
        read_slot(1);
        read_slot(2);
        read_slot(3);
        add_read(addr_status, word_w'(1) << 8, word_w'(1) << 8);
        add_wait();
        add_read(addr_status, word_w'(sw_head), '1);
        // Wraparound past slot 15
        for (int k = 7; k < ring_depth + 3; k++) begin
            add_char(k % ring_depth);
        end
        set_head(3);
        add_wait();
        add_read(addr_status, word_w'(sw_head), '1);
        // Head write while a frame is on the line
        for (int k = 3; k <= 5; k++) begin
            add_char(k);
        end
        set_head(4);
        read_slot(3);
        read_slot(4);
        read_slot(5);
        add_read(addr_head, word_w'(4), '1);
        set_head(6);
        add_wait();
        add_read(addr_status, word_w'(sw_head), '1);
        read_slot(3);
        read_slot(4);
        read_slot(5);
        // Status and unused addresses ignore writes
        add_write(addr_status, '1);
        add_write(addr_slot0 + addr_w'(ring_depth), 32'hdead_beef);
        add_write(addr_w'(31), 32'h1234_5678);
        add_read(addr_status, word_w'(sw_head), '1);
        add_read(addr_slot0 + addr_w'(ring_depth), '0, '1);
        add_read(addr_w'(31), '0, '1);
        add_read(addr_head, word_w'(sw_head), '1);
        read_slot(0);
        read_slot(13);
    endtask

    // Poll status until tail catches head and the line is idle
    task automatic wait_idle(input logic [idx_w-1:0] head);
        logic [word_w-1:0] st;
        bus_addr = addr_status;
        do begin
            @(posedge clk);
            #1;
            st = bus_rdata;
        end while (st[idx_w-1:0] != head || st[8]);
    endtask

    task automatic apply_entry(input entry_t e);
        @(posedge clk);
        #1;
        bus_we = 1'b0;
        chk_en = 1'b0;
        case (e.op)
            op_write: begin
                bus_we    = 1'b1;
                bus_addr  = e.addr;
                bus_wdata = e.data;
            end
            op_read: begin
                bus_addr = e.addr;
                chk_en   = 1'b1;
                chk_data = e.exp_val;
                chk_mask = e.mask;
            end
            default: begin
                wait_idle(e.data[idx_w-1:0]);
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        bus_we      = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;
        chk_en      = 1'b0;
        chk_data    = '0;
        chk_mask    = '0;
        end_of_test = 1'b0;
        rng         = 32'd54;
        sw_head     = '0;
        n_bytes     = 0;
        for (int i = 0; i < ring_depth; i++) begin
            sw_slots[i] = '0;
        end
        build_table();
        cycle_limit = n_bytes * 11 * clks_per_bit + tbl.size() * 4 + 200;

        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        foreach (tbl[i]) begin
            apply_entry(tbl[i]);
        end
        @(posedge clk);
        #1;
        bus_we = 1'b0;
        chk_en = 1'b0;
        repeat (2) @(posedge clk);  // Let the last read compare
        end_of_test = 1'b1;
        @(posedge clk);

        $display("Errors: read %0d, byte %0d, protocol %0d, left in ring %0d",
                 read_errs, byte_errs, proto_errs, pending_left);
        if (read_errs + byte_errs + proto_errs + pending_left == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
console_pkg.sv
tx_ctrl_if.sv
console_regs.sv
uart_tx_fsm.sv
baud_timer.sv
tx_shifter.sv
uart_console.sv
console_checker.sv
tb_uart_console.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_console
LOG       ?= sim.log
VFLAGS    ?=

SRCS := $(shell cat project.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): project.f $(SRCS)
	$(VERILATOR) --binary --top-module $(TOP) $(VFLAGS) -f project.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF -- '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(TOP) $(VFLAGS) -f project.f

clean:
	rm -rf obj_dir $(LOG)
